// ==== build.sh ====
#!/usr/bin/env bash
# Compile and run the scanner testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module scannerTb \
	-f scanner.f -o simScanner
if [ $? -ne 0 ]; then
	echo "Compile failed"
	exit 1
fi

./obj_dir/simScanner > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qF '*** FAILED ***' "$LOG"; then
	exit 1
fi
if ! grep -qF '*** PASSED ***' "$LOG"; then
	echo "No verdict found in $LOG"
	exit 1
fi
exit 0

// ==== hdl/fillCounter.sv ====
`timescale 1ns/1ps
`default_nettype none

module fillCounter #(
	parameter int FILL_MAX = 9,
	parameter int DIV_LEN  = 8
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 countEn,
	input  logic                 fillClear,
	output logic [3:0]           level,
	output scannerPkg::fillEvent events
);

	localparam int DIV_W = $clog2(DIV_LEN);

	logic [DIV_W-1:0] divCnt;
	logic             tick;
	logic             inc;
	logic [3:0]       levelNext;

	assign tick      = (divCnt == DIV_W'(DIV_LEN - 1));
	assign levelNext = level + 4'd1;

	// Saturate at FILL_MAX, clear has priority
	assign inc = tick && countEn && !fillClear && (level < 4'(FILL_MAX));

	// Free running slow tick divider
	always_ff @(posedge clk) begin
		if (rst) begin
			divCnt <= '0;
		end else if (tick) begin
			divCnt <= '0;
		end else begin
			divCnt <= divCnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			level <= 4'd0;
		end else if (fillClear) begin
			level <= 4'd0; // Buffer drained by transfer
		end else if (inc) begin
			level <= levelNext;
		end
	end

	// Flags line up with the level update, so a held level never repeats them
	always_ff @(posedge clk) begin
		if (rst) begin
			events <= '0;
		end else begin
			events.nearFull   <= inc && (levelNext == 4'(FILL_MAX - 2));
			events.almostFull <= inc && (levelNext == 4'(FILL_MAX - 1));
			events.full       <= inc && (levelNext == 4'(FILL_MAX));
		end
	end

endmodule

`default_nettype wire

// ==== hdl/scanCtrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module scanCtrl (
	input  logic                 clk,
	input  logic                 rst,
	input  logic [1:0]           localTransferIn,
	input  logic                 readyForTransfer,
	input  scannerPkg::fillEvent events,
	input  logic [3:0]           level,
	input  logic                 busy,
	input  logic                 done,
	output logic                 countEn,
	output logic                 fillClear,
	output logic                 txStart,
	output scannerPkg::frameWord txWord
);

	import scannerPkg::*;

	// Transfer sub-steps
	localparam logic [1:0] xSendCmd  = 2'd0;
	localparam logic [1:0] xWaitCmd  = 2'd1;
	localparam logic [1:0] xSendData = 2'd2;
	localparam logic [1:0] xWaitData = 2'd3;

	scanState   state;
	scanState   stateNext;
	logic [1:0] xPhase;
	localCmd    lc;

	// Pending command queue, head at index 0
	cmdCode     cmdQ [3];
	logic [1:0] qCount;
	logic [1:0] wrIdx;
	logic       push;
	logic       pop;
	cmdCode     pushCode;

	logic       qIssue;
	logic       xIssue;
	logic       xDone;

	assign lc      = localCmd'(localTransferIn);
	assign countEn = (state == sActive);

	// Threshold events only count while scanning
	assign push = (state == sActive) && (events.nearFull || events.almostFull || events.full);

	always_comb begin
		if (events.full) begin
			pushCode = cmdBufferFull;
		end else if (events.almostFull) begin
			pushCode = cmdStartScanning;
		end else begin
			pushCode = cmdReadyToTransfer;
		end
	end

	// Queued frames go first, transfer frames only once the queue is drained
	assign qIssue = !busy && (qCount != 2'd0);
	assign xIssue = !busy && (qCount == 2'd0) && (state == sTransfer)
		&& ((xPhase == xSendCmd) || (xPhase == xSendData));
	assign pop     = qIssue;
	assign txStart = qIssue || xIssue;

	always_comb begin
		txWord = '0;
		if (qIssue) begin
			txWord.cmd = cmdQ[0];
		end else if (xPhase == xSendData) begin
			txWord.data.pad   = 4'h0;
			txWord.data.level = level; // Data frame carries the fill level
		end else begin
			txWord.cmd = cmdDataTransfer;
		end
	end

	assign xDone     = (state == sTransfer) && (xPhase == xWaitData) && done;
	assign fillClear = xDone;

	assign wrIdx = pop ? (qCount - 2'd1) : qCount;

	// Queue storage, later write wins on the same slot
	always_ff @(posedge clk) begin
		if (pop) begin
			cmdQ[0] <= cmdQ[1];
			cmdQ[1] <= cmdQ[2];
		end
		if (push) begin
			cmdQ[wrIdx] <= pushCode;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			qCount <= 2'd0;
		end else begin
			case ({push, pop})
				2'b10:   qCount <= qCount + 2'd1;
				2'b01:   qCount <= qCount - 2'd1;
				default: qCount <= qCount;
			endcase
		end
	end

	always_comb begin
		stateNext = state;
		case (state)
			sIdle: begin
				if (lc == lcStartScan) begin
					stateNext = sActive;
				end
			end
			sActive: begin
				if (events.full) begin
					stateNext = readyForTransfer ? sTransfer : sStandby;
				end
			end
			sStandby: begin
				if (readyForTransfer || (lc == lcPeerHalf)) begin
					stateNext = sTransfer;
				end
			end
			sTransfer: begin
				if (xDone) begin
					stateNext = sIdle;
				end
			end
			default: stateNext = sIdle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= sIdle;
		end else begin
			state <= stateNext;
		end
	end

	// Two-frame transfer: command 7, then the data word
	always_ff @(posedge clk) begin
		if (rst) begin
			xPhase <= xSendCmd;
		end else if (state != sTransfer) begin
			xPhase <= xSendCmd;
		end else begin
			case (xPhase)
				xSendCmd:  if (xIssue) xPhase <= xWaitCmd;
				xWaitCmd:  if (done) xPhase <= xSendData;
				xSendData: if (xIssue) xPhase <= xWaitData;
				xWaitData: if (done) xPhase <= xSendCmd;
				default:   xPhase <= xSendCmd;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hdl/scannerPkg.sv ====
`default_nettype none

package scannerPkg;

	// Controller states
	typedef enum logic [1:0] {
		sIdle     = 2'd0,
		sActive   = 2'd1,
		sStandby  = 2'd2,
		sTransfer = 2'd3
	} scanState;

	// Local controller commands on localTransferIn
	typedef enum logic [1:0] {
		lcNone      = 2'b00,
		lcStartScan = 2'b01,
		lcPeerHalf  = 2'b10
	} localCmd;

	// Command frame codes sent over the serial link
	typedef enum logic [7:0] {
		cmdReadyToTransfer = 8'd2,
		cmdStartScanning   = 8'd3,
		cmdBufferFull      = 8'd4,
		cmdDataTransfer    = 8'd7
	} cmdCode;

	// Data frame layout, fill level in the low nibble
	typedef struct packed {
		logic [3:0] pad;
		logic [3:0] level;
	} fillData;

	// One serial frame, either a command or a data word
	typedef union packed {
		cmdCode  cmd;
		fillData data;
	} frameWord;

	// Threshold crossings, each a one-cycle pulse
	typedef struct packed {
		logic nearFull;   // FILL_MAX - 2
		logic almostFull; // FILL_MAX - 1
		logic full;       // FILL_MAX
	} fillEvent;

	// Level register is 4 bits wide
	localparam int FILL_MAX_DEFAULT = 9;

	// Slow tick period in clk cycles
	localparam int DIV_LEN_DEFAULT = 8;

endpackage

`default_nettype wire

// ==== hdl/scannerTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module scannerTop #(
	parameter int FILL_MAX = scannerPkg::FILL_MAX_DEFAULT,
	parameter int DIV_LEN  = scannerPkg::DIV_LEN_DEFAULT
) (
	input  logic       clk,
	input  logic       rst,
	input  logic       readyForTransfer,
	input  logic [1:0] localTransferIn,
	output logic       clkOut,
	output logic       dataOut
);

	import scannerPkg::*;

	fillEvent   events;
	logic [3:0] level;
	logic       countEn;
	logic       fillClear;
	logic       txStart;
	frameWord   txWord;
	logic       busy;
	logic       done;

	fillCounter #(
		.FILL_MAX (FILL_MAX),
		.DIV_LEN  (DIV_LEN)
	) fillCounterInst (
		.clk       (clk),
		.rst       (rst),
		.countEn   (countEn),
		.fillClear (fillClear),
		.level     (level),
		.events    (events)
	);

	scanCtrl scanCtrlInst (
		.clk              (clk),
		.rst              (rst),
		.localTransferIn  (localTransferIn),
		.readyForTransfer (readyForTransfer),
		.events           (events),
		.level            (level),
		.busy             (busy),
		.done             (done),
		.countEn          (countEn),
		.fillClear        (fillClear),
		.txStart          (txStart),
		.txWord           (txWord)
	);

	serialTx serialTxInst (
		.clk     (clk),
		.rst     (rst),
		.txStart (txStart),
		.txWord  (txWord),
		.busy    (busy),
		.done    (done),
		.clkOut  (clkOut),
		.dataOut (dataOut)
	);

endmodule

`default_nettype wire

// ==== hdl/serialTx.sv ====
`timescale 1ns/1ps
`default_nettype none

module serialTx (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 txStart,
	input  scannerPkg::frameWord txWord,
	output logic                 busy,
	output logic                 done,
	output logic                 clkOut,
	output logic                 dataOut
);

	logic       accept;
	logic [2:0] bitCnt;
	logic [7:0] shiftReg;

	// Start is dropped while a frame is on the wire
	assign accept = txStart && !busy;

	assign done    = busy && (bitCnt == 3'd7); // Last bit cycle
	assign clkOut  = busy;                    // One strobe per bit
	assign dataOut = busy && shiftReg[0];

	always_ff @(posedge clk) begin
		if (rst) begin
			busy   <= 1'b0;
			bitCnt <= 3'd0;
		end else if (accept) begin
			busy   <= 1'b1;
			bitCnt <= 3'd0;
		end else if (busy) begin
			bitCnt <= bitCnt + 3'd1;
			if (bitCnt == 3'd7) begin
				busy <= 1'b0; // Leaves at least one idle cycle
			end
		end
	end

	// LSB first
	always_ff @(posedge clk) begin
		if (accept) begin
			shiftReg <= txWord;
		end else if (busy) begin
			shiftReg <= {1'b0, shiftReg[7:1]};
		end
	end

endmodule

`default_nettype wire

// ==== scanner.f ====
hdl/scannerPkg.sv
hdl/fillCounter.sv
hdl/scanCtrl.sv
hdl/serialTx.sv
hdl/scannerTop.sv
tests/scannerTop_chk.sv
tests/scannerTb.sv

// ==== tests/scannerTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module scannerTb;

	import scannerPkg::*;

	localparam int FILL = FILL_MAX_DEFAULT;
	localparam int CYCLE_LIMIT = 2500; // About five scans plus the idle windows

	logic       clk;
	logic       rst;
	logic       readyForTransfer;
	logic [1:0] localTransferIn;
	logic       clkOut;
	logic       dataOut;

	logic [7:0] expQ [$]; // Frames still owed by the DUT
	logic [7:0] shiftIn;
	int         bitPos = 0;
	int         errCount = 0;
	int         testsRun = 0;
	int         testsFailed = 0;
	int         cycles = 0;
	integer     seed = 32'hb612e685;

	scannerTop dut (
		.clk              (clk),
		.rst              (rst),
		.readyForTransfer (readyForTransfer),
		.localTransferIn  (localTransferIn),
		.clkOut           (clkOut),
		.dataOut          (dataOut)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) cycles <= cycles + 1;

	initial begin
		while (cycles < CYCLE_LIMIT) @(posedge clk);
		$display("Timeout after %0d cycles, the run did not finish", cycles);
		$display("*** FAILED ***");
		$finish;
	end

	function automatic void checkFrame(input logic [7:0] got);
		logic [7:0] want;
		if (expQ.size() == 0) return; // Already reported at its first strobe
		want = expQ.pop_front();
		assert (got == want) else begin
			errCount++;
			$display("mismatch at %0t: frame 0x%02h, expected 0x%02h", $time, got, want);
		end
	endfunction

	// Deserializer, LSB first, sampled mid cycle
	always @(negedge clk) begin
		if (rst) begin
			bitPos = 0;
		end else if (clkOut) begin
			if (bitPos == 0) begin
				assert (expQ.size() != 0) else begin
					errCount++;
					$display("A frame started at %0t while none was expected", $time);
				end
			end
			shiftIn[bitPos[2:0]] = dataOut;
			bitPos++;
			if (bitPos == 8) begin
				checkFrame(shiftIn);
				bitPos = 0;
			end
		end else begin
			assert (!dataOut) else begin
				errCount++;
				$display("dataOut was high without a strobe at %0t", $time);
			end
		end
	end

	task automatic nextCycle();
		@(posedge clk);
		#1;
	endtask

	task automatic idleCycles(input int n);
		repeat (n) nextCycle();
	endtask

	task automatic sendLocal(input localCmd c);
		localTransferIn = c;
		nextCycle();
		localTransferIn = lcNone;
	endtask

	task automatic queueScanFrames();
		expQ.push_back(8'd2); // Fill level FILL_MAX - 2
		expQ.push_back(8'd3);
		expQ.push_back(8'd4); // Buffer full
	endtask

	task automatic queueTransferFrames();
		expQ.push_back(8'd7);
		expQ.push_back(8'(FILL)); // Data frame holds the full level
	endtask

	task automatic drainFrames();
		while (expQ.size() != 0) nextCycle();
	endtask

	task automatic reportTest(input string name, input int errBefore);
		testsRun++;
		if (errCount == errBefore) begin
			$display("test %0d %s: ok", testsRun, name);
		end else begin
			testsFailed++;
			$display("test %0d %s: failed with %0d errors", testsRun, name,
				errCount - errBefore);
		end
	endtask

	initial begin
		int errBefore;
		int waitLen;
		rst = 1'b1;
		readyForTransfer = 1'b0;
		localTransferIn = lcNone;
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;

		errBefore = errCount;
		idleCycles(30);
		reportTest("quiet after reset", errBefore);

		// Receiver not ready, scan ends in standby
		errBefore = errCount;
		queueScanFrames();
		sendLocal(lcStartScan);
		drainFrames();
		waitLen = 16 + int'($unsigned($random(seed)) % 48);
		idleCycles(waitLen);
		reportTest("scan frames then standby", errBefore);

		errBefore = errCount;
		queueTransferFrames();
		readyForTransfer = 1'b1;
		drainFrames();
		idleCycles(20);
		reportTest("transfer on ready", errBefore);

		// Ready already high, no stall at full
		errBefore = errCount;
		queueScanFrames();
		queueTransferFrames();
		sendLocal(lcStartScan);
		drainFrames();
		idleCycles(20);
		readyForTransfer = 1'b0;
		reportTest("scan with receiver ready", errBefore);

		errBefore = errCount;
		queueScanFrames();
		sendLocal(lcStartScan);
		drainFrames();
		idleCycles(10);
		queueTransferFrames();
		sendLocal(lcPeerHalf);
		drainFrames();
		idleCycles(20);
		reportTest("transfer on peer half full", errBefore);

		errBefore = errCount;
		sendLocal(lcPeerHalf);
		sendLocal(lcNone);
		idleCycles(200);
		reportTest("idle ignores other commands", errBefore);

		$display("tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errCount);
		if (testsFailed == 0 && errCount == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tests/scannerTop_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module scannerTop_chk #(
	parameter int FILL_MAX = 9
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 clkOut,
	input  logic                 txStart,
	input  logic                 busy,
	input  logic [3:0]           level,
	input  scannerPkg::scanState state
);

	import scannerPkg::*;

	logic [3:0] strobeRun; // Consecutive strobe cycles so far

	always_ff @(posedge clk) begin
		if (rst) begin
			strobeRun <= 4'd0;
		end else if (clkOut) begin
			strobeRun <= strobeRun + 4'd1;
		end else begin
			strobeRun <= 4'd0;
		end
	end

	// Strobes open only on a start the transmitter accepted
	strobeAfterStart: assert property (@(posedge clk) disable iff (rst)
		$rose(clkOut) |-> $past(txStart && !busy))
		else $error("clkOut strobes began without an accepted start");

	// A frame ends only after its eighth strobe
	frameLength: assert property (@(posedge clk) disable iff (rst)
		$fell(clkOut) |-> (strobeRun == 4'd8))
		else $error("frame ended after %0d strobes", strobeRun);

	frameNotLong: assert property (@(posedge clk) disable iff (rst) strobeRun <= 4'd8)
		else $error("frame longer than eight strobes");

	levelBound: assert property (@(posedge clk) disable iff (rst) level <= 4'(FILL_MAX))
		else $error("fill level %0d above limit", level);

	// Level only grows while scanning
	levelRiseActive: assert property (@(posedge clk) disable iff (rst)
		(level > $past(level)) |-> ($past(state) == sActive))
		else $error("fill level rose outside the active state");

endmodule

bind scannerTop scannerTop_chk #(.FILL_MAX(FILL_MAX)) chk (
	.clk     (clk),
	.rst     (rst),
	.clkOut  (clkOut),
	.txStart (txStart),
	.busy    (busy),
	.level   (level),
	.state   (scanCtrlInst.state)
);

`default_nettype wire
